/* risc8_pkg.sv */
/*
 * shared widths, types and opcode fields of the trimmed AVR subset
 * opcodes outside this subset decode as no-ops
 * H, T and I are never written and read back as zero
 */
package risc8_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] opcode_t;
	// program memory word address
	typedef logic [15:0] pc_t;
	// data space byte address, I/O sits at IO_BASE and up
	typedef logic [15:0] addr_t;
	typedef logic [4:0] reg_sel_t;
	typedef logic [7:0] sreg_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_EOR,
		ALU_MOV
	} alu_op_t;

	typedef enum logic [2:0] {
		CLASS_ALU_REG,
		CLASS_ALU_IMM,
		CLASS_RJMP,
		CLASS_BRBX,
		CLASS_OUT,
		CLASS_INVALID
	} instr_class_t;

	// I/O address 0 maps to data address 0x20
	localparam byte_t IO_BASE = 8'h20;

	// status register bit positions
	localparam logic [2:0] FLAG_C = 3'd0;
	localparam logic [2:0] FLAG_Z = 3'd1;
	localparam logic [2:0] FLAG_N = 3'd2;
	localparam logic [2:0] FLAG_V = 3'd3;
	localparam logic [2:0] FLAG_S = 3'd4;

	// register-register forms, matched on opcode[15:10]
	localparam logic [5:0] OPC_CPC = 6'b000001;
	localparam logic [5:0] OPC_SBC = 6'b000010;
	localparam logic [5:0] OPC_ADD = 6'b000011;
	localparam logic [5:0] OPC_CP = 6'b000101;
	localparam logic [5:0] OPC_SUB = 6'b000110;
	localparam logic [5:0] OPC_ADC = 6'b000111;
	localparam logic [5:0] OPC_AND = 6'b001000;
	localparam logic [5:0] OPC_EOR = 6'b001001;
	localparam logic [5:0] OPC_OR = 6'b001010;
	localparam logic [5:0] OPC_MOV = 6'b001011;

	// immediate forms and rjmp, matched on opcode[15:12]
	localparam logic [3:0] OPC_CPI = 4'b0011;
	localparam logic [3:0] OPC_SBCI = 4'b0100;
	localparam logic [3:0] OPC_SUBI = 4'b0101;
	localparam logic [3:0] OPC_ORI = 4'b0110;
	localparam logic [3:0] OPC_ANDI = 4'b0111;
	localparam logic [3:0] OPC_LDI = 4'b1110;
	localparam logic [3:0] OPC_RJMP = 4'b1100;

	// brbs/brbc and out, matched on opcode[15:11]
	localparam logic [4:0] OPC_BRBX = 5'b11110;
	localparam logic [4:0] OPC_OUT = 5'b10111;

endpackage

/* risc8_alu.sv */
/*
 * 8-bit ALU for the kept operations, AVR rules for C Z N V S
 * with use_carry a subtract can only keep Z set, never set it
 * H, T and I come out as zero
 */
module risc8_alu
	import risc8_pkg::*;
(
	input  alu_op_t op,
	input  logic    use_carry,
	input  byte_t   rd_in,
	input  byte_t   rr_in,
	input  sreg_t   sreg_in,
	output byte_t   result,
	output sreg_t   sreg_out
);
	logic carry_in;
	logic [8:0] wide;
	logic zero;

	assign carry_in = use_carry & sreg_in[FLAG_C];

	always_comb begin
		wide = '0;
		result = rr_in;
		sreg_out = sreg_in;
		case (op)
			ALU_ADD: begin
				wide = {1'b0, rd_in} + {1'b0, rr_in} + 9'(carry_in);
				result = wide[7:0];
				sreg_out[FLAG_C] = wide[8];
				// signed overflow when both inputs share a sign the result lacks
				sreg_out[FLAG_V] = (rd_in[7] & rr_in[7] & ~result[7])
					| (~rd_in[7] & ~rr_in[7] & result[7]);
			end
			ALU_SUB: begin
				wide = {1'b0, rd_in} - {1'b0, rr_in} - 9'(carry_in);
				result = wide[7:0];
				// top bit of the 9-bit difference is the borrow
				sreg_out[FLAG_C] = wide[8];
				sreg_out[FLAG_V] = (rd_in[7] & ~rr_in[7] & ~result[7])
					| (~rd_in[7] & rr_in[7] & result[7]);
			end
			ALU_AND: begin
				result = rd_in & rr_in;
				sreg_out[FLAG_V] = 1'b0;
			end
			ALU_OR: begin
				result = rd_in | rr_in;
				sreg_out[FLAG_V] = 1'b0;
			end
			ALU_EOR: begin
				result = rd_in ^ rr_in;
				sreg_out[FLAG_V] = 1'b0;
			end
			// mov passes Rr and keeps every flag
			default: result = rr_in;
		endcase

		zero = (result == 8'h00);
		if (op != ALU_MOV) begin
			sreg_out[FLAG_N] = result[7];
			// sbc/cpc chain Z across bytes of a multi-byte compare
			if (op == ALU_SUB && use_carry)
				sreg_out[FLAG_Z] = zero & sreg_in[FLAG_Z];
			else
				sreg_out[FLAG_Z] = zero;
			// logic ops cleared V above, so S follows N there
			sreg_out[FLAG_S] = sreg_out[FLAG_N] ^ sreg_out[FLAG_V];
		end
		// H, T and I are not implemented
		sreg_out[7:5] = 3'b000;
	end

endmodule

/* risc8_regs.sv */
/*
 * 32 x 8 register file in flops, two read ports and one write port
 * read data shows up one clock after the index is presented
 */
module risc8_regs
	import risc8_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  reg_sel_t sel_a,
	input  reg_sel_t sel_b,
	output byte_t    reg_a,
	output byte_t    reg_b,
	input  reg_sel_t wr_sel,
	input  byte_t    wr_data,
	input  logic     wr_en
);
	byte_t rf [32];
	logic hit_a;
	logic hit_b;

	// a write landing on the same edge as a read would be missed
	// by the array, so forward it straight into the read register
	assign hit_a = wr_en && (wr_sel == sel_a);
	assign hit_b = wr_en && (wr_sel == sel_b);

	always_ff @(posedge clk) begin
		if (wr_en)
			rf[wr_sel] <= wr_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_a <= '0;
			reg_b <= '0;
		end else begin
			// port a carries Rd, port b carries Rr
			reg_a <= hit_a ? wr_data : rf[sel_a];
			reg_b <= hit_b ? wr_data : rf[sel_b];
		end
	end

endmodule

/* risc8_decode.sv */
/*
 * first pipeline stage: fetch, decode, branch and OUT sequencing
 * pc is combinational and expects cdata one clock later
 * branches see the flags the execute stage produces in the same cycle
 */
module risc8_decode
	import risc8_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  opcode_t  cdata,
	output pc_t      pc,
	input  sreg_t    next_sreg,
	input  byte_t    reg_a,
	output reg_sel_t sel_a,
	output reg_sel_t sel_b,
	output alu_op_t  ex_op,
	output logic     ex_use_carry,
	output logic     ex_store,
	output logic     ex_const,
	output byte_t    ex_const_value,
	output reg_sel_t ex_sel_d,
	output addr_t    data_addr,
	output logic     data_wen,
	output byte_t    data_write
);
	// OUT spends one cycle waiting for Rr to come out of the register file
	typedef enum logic {
		PHASE_ISSUE,
		PHASE_WRITE
	} phase_t;

	pc_t reg_pc;
	pc_t next_pc;
	phase_t phase;
	phase_t next_phase;
	// low until the first opcode fetched after reset has arrived
	logic fetch_valid;
	opcode_t saved_opcode;
	opcode_t opcode;
	instr_class_t instr_class;
	alu_op_t dec_op;
	logic dec_carry;
	logic dec_store;
	logic reg_hit;
	logic imm_hit;
	alu_op_t nx_op;
	logic nx_carry;
	logic nx_store;
	logic nx_const;
	reg_sel_t op_rd;
	reg_sel_t op_rr;
	reg_sel_t op_rdi;
	byte_t op_k;
	logic [5:0] io_addr;
	pc_t simm12;
	pc_t simm7;

	// second OUT cycle replays the held opcode
	assign opcode = (phase == PHASE_WRITE) ? saved_opcode : cdata;

	assign op_rd = opcode[8:4];
	assign op_rr = {opcode[9], opcode[3:0]};
	// immediates only reach r16..r31
	assign op_rdi = {1'b1, opcode[7:4]};
	assign op_k = {opcode[11:8], opcode[3:0]};
	assign io_addr = {opcode[10:9], opcode[3:0]};
	assign simm12 = {{4{opcode[11]}}, opcode[11:0]};
	assign simm7 = {{9{opcode[9]}}, opcode[9:3]};

	always_comb begin
		dec_op = ALU_MOV;
		dec_carry = 1'b0;
		dec_store = 1'b1;
		reg_hit = 1'b1;
		imm_hit = 1'b1;
		case (opcode[15:10])
			OPC_ADD: dec_op = ALU_ADD;
			OPC_ADC: begin
				dec_op = ALU_ADD;
				dec_carry = 1'b1;
			end
			OPC_SUB: dec_op = ALU_SUB;
			OPC_SBC: begin
				dec_op = ALU_SUB;
				dec_carry = 1'b1;
			end
			// compares only touch sreg
			OPC_CP: begin
				dec_op = ALU_SUB;
				dec_store = 1'b0;
			end
			OPC_CPC: begin
				dec_op = ALU_SUB;
				dec_carry = 1'b1;
				dec_store = 1'b0;
			end
			OPC_AND: dec_op = ALU_AND;
			OPC_OR: dec_op = ALU_OR;
			OPC_EOR: dec_op = ALU_EOR;
			OPC_MOV: dec_op = ALU_MOV;
			default: reg_hit = 1'b0;
		endcase
		case (opcode[15:12])
			OPC_CPI: begin
				dec_op = ALU_SUB;
				dec_store = 1'b0;
			end
			OPC_SBCI: begin
				dec_op = ALU_SUB;
				dec_carry = 1'b1;
			end
			OPC_SUBI: dec_op = ALU_SUB;
			OPC_ORI: dec_op = ALU_OR;
			OPC_ANDI: dec_op = ALU_AND;
			OPC_LDI: dec_op = ALU_MOV;
			default: imm_hit = 1'b0;
		endcase
		if (reg_hit)
			instr_class = CLASS_ALU_REG;
		else if (imm_hit)
			instr_class = CLASS_ALU_IMM;
		else if (opcode[15:12] == OPC_RJMP)
			instr_class = CLASS_RJMP;
		else if (opcode[15:11] == OPC_BRBX)
			instr_class = CLASS_BRBX;
		else if (opcode[15:11] == OPC_OUT)
			instr_class = CLASS_OUT;
		else
			instr_class = CLASS_INVALID;
	end

	always_comb begin
		// default is a no-op that advances by one word
		next_pc = reg_pc + 16'd1;
		next_phase = PHASE_ISSUE;
		sel_a = op_rd;
		sel_b = op_rr;
		nx_op = ALU_MOV;
		nx_carry = 1'b0;
		nx_store = 1'b0;
		nx_const = 1'b0;
		data_wen = 1'b0;
		if (!fetch_valid) begin
			// cdata is still stale, refetch word 0
			next_pc = reg_pc;
		end else begin
			case (instr_class)
				CLASS_ALU_REG: begin
					nx_op = dec_op;
					nx_carry = dec_carry;
					nx_store = dec_store;
				end
				CLASS_ALU_IMM: begin
					sel_a = op_rdi;
					nx_op = dec_op;
					nx_carry = dec_carry;
					nx_store = dec_store;
					nx_const = 1'b1;
				end
				CLASS_RJMP: next_pc = reg_pc + simm12 + 16'd1;
				CLASS_BRBX: begin
					// opcode[10] clear is brbs, set is brbc
					if (next_sreg[opcode[2:0]] != opcode[10])
						next_pc = reg_pc + simm7 + 16'd1;
				end
				CLASS_OUT: begin
					if (phase == PHASE_ISSUE) begin
						next_phase = PHASE_WRITE;
						next_pc = reg_pc;
					end else begin
						data_wen = 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

	assign pc = next_pc;
	assign data_addr = addr_t'(io_addr) + addr_t'(IO_BASE);
	assign data_write = reg_a;

	always_ff @(posedge clk) begin
		saved_opcode <= opcode;
		ex_const_value <= op_k;
		ex_sel_d <= (instr_class == CLASS_ALU_IMM) ? op_rdi : op_rd;
		if (reset) begin
			reg_pc <= '0;
			phase <= PHASE_ISSUE;
			fetch_valid <= 1'b0;
			ex_op <= ALU_MOV;
			ex_use_carry <= 1'b0;
			ex_store <= 1'b0;
			ex_const <= 1'b0;
		end else begin
			reg_pc <= next_pc;
			phase <= next_phase;
			fetch_valid <= 1'b1;
			ex_op <= nx_op;
			ex_use_carry <= nx_carry;
			ex_store <= nx_store;
			ex_const <= nx_const;
		end
	end

endmodule

/* risc8_execute.sv */
/*
 * second pipeline stage: operand select, ALU, write-back and sreg
 * write-back and next_sreg are combinational from the registered controls
 */
module risc8_execute
	import risc8_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  alu_op_t  ex_op,
	input  logic     ex_use_carry,
	input  logic     ex_store,
	input  logic     ex_const,
	input  byte_t    ex_const_value,
	input  reg_sel_t ex_sel_d,
	input  byte_t    reg_a,
	input  byte_t    reg_b,
	output reg_sel_t wr_sel,
	output byte_t    wr_data,
	output logic     wr_en,
	output sreg_t    next_sreg
);
	sreg_t sreg;
	byte_t operand_b;

	// immediates replace Rr as the second operand
	assign operand_b = ex_const ? ex_const_value : reg_b;

	risc8_alu alu (
		.op(ex_op),
		.use_carry(ex_use_carry),
		.rd_in(reg_a),
		.rr_in(operand_b),
		.sreg_in(sreg),
		.result(wr_data),
		.sreg_out(next_sreg)
	);

	// compares leave ex_store low but still update sreg below
	assign wr_sel = ex_sel_d;
	assign wr_en = ex_store;

	always_ff @(posedge clk) begin
		if (reset)
			sreg <= '0;
		else
			sreg <= next_sreg;
	end

endmodule

/* risc8_core.sv */
/*
 * two-stage AVR-style core, top level
 * program memory must return cdata one clock after pc
 * the data port is write only with no back-pressure
 */
module risc8_core
	import risc8_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	output pc_t     pc,
	input  opcode_t cdata,
	output addr_t   data_addr,
	output logic    data_wen,
	output byte_t   data_write
);
	reg_sel_t sel_a;
	reg_sel_t sel_b;
	byte_t reg_a;
	byte_t reg_b;
	alu_op_t ex_op;
	logic ex_use_carry;
	logic ex_store;
	logic ex_const;
	byte_t ex_const_value;
	reg_sel_t ex_sel_d;
	reg_sel_t wr_sel;
	byte_t wr_data;
	logic wr_en;
	// flags of the instruction now in execute, used by branches in decode
	sreg_t next_sreg;

	risc8_decode decode (
		.clk(clk),
		.reset(reset),
		.cdata(cdata),
		.pc(pc),
		.next_sreg(next_sreg),
		.reg_a(reg_a),
		.sel_a(sel_a),
		.sel_b(sel_b),
		.ex_op(ex_op),
		.ex_use_carry(ex_use_carry),
		.ex_store(ex_store),
		.ex_const(ex_const),
		.ex_const_value(ex_const_value),
		.ex_sel_d(ex_sel_d),
		.data_addr(data_addr),
		.data_wen(data_wen),
		.data_write(data_write)
	);

	risc8_regs regs (
		.clk(clk),
		.reset(reset),
		.sel_a(sel_a),
		.sel_b(sel_b),
		.reg_a(reg_a),
		.reg_b(reg_b),
		.wr_sel(wr_sel),
		.wr_data(wr_data),
		.wr_en(wr_en)
	);

	risc8_execute execute (
		.clk(clk),
		.reset(reset),
		.ex_op(ex_op),
		.ex_use_carry(ex_use_carry),
		.ex_store(ex_store),
		.ex_const(ex_const),
		.ex_const_value(ex_const_value),
		.ex_sel_d(ex_sel_d),
		.reg_a(reg_a),
		.reg_b(reg_b),
		.wr_sel(wr_sel),
		.wr_data(wr_data),
		.wr_en(wr_en),
		.next_sreg(next_sreg)
	);

endmodule

/* tb_risc8_model.svh */
/*
 * instruction-level reference for the kept AVR subset
 * runs until an RJMP to itself and returns the expected OUT writes as {addr, data}
 */
`ifndef TB_RISC8_MODEL_SVH
`define TB_RISC8_MODEL_SVH

function automatic void expected_writes(input opcode_t prog[$], output logic [23:0] writes[$],
		output int steps);
	byte_t r [32];
	logic [7:0] f;
	int pc;
	int kind;
	logic carry;
	logic store;
	logic imm;
	opcode_t w;
	reg_sel_t d;
	byte_t a;
	byte_t b;
	byte_t res;
	logic cin;
	logic c;
	logic v;
	logic n;
	logic z;
	writes.delete();
	steps = 0;
	pc = 0;
	f = 8'h00;
	for (int i = 0; i < 32; i++)
		r[i] = 8'h00;
	while (steps < 4000 && pc >= 0 && pc < prog.size()) begin
		w = prog[pc];
		steps++;
		// kind codes 0 none, 1 add, 2 sub, 3 and, 4 or, 5 eor, 6 move
		kind = 0;
		carry = 1'b0;
		store = 1'b1;
		imm = 1'b0;
		d = w[8:4];
		b = r[{w[9], w[3:0]}];
		case (w[15:10])
			6'b000011: kind = 1;
			6'b000111: begin
				kind = 1;
				carry = 1'b1;
			end
			6'b000110: kind = 2;
			6'b000010: begin
				kind = 2;
				carry = 1'b1;
			end
			6'b000101: begin
				kind = 2;
				store = 1'b0;
			end
			6'b000001: begin
				kind = 2;
				carry = 1'b1;
				store = 1'b0;
			end
			6'b001000: kind = 3;
			6'b001010: kind = 4;
			6'b001001: kind = 5;
			6'b001011: kind = 6;
			default: ;
		endcase
		case (w[15:12])
			4'b0011: begin
				kind = 2;
				store = 1'b0;
				imm = 1'b1;
			end
			4'b0100: begin
				kind = 2;
				carry = 1'b1;
				imm = 1'b1;
			end
			4'b0101: begin
				kind = 2;
				imm = 1'b1;
			end
			4'b0110: begin
				kind = 4;
				imm = 1'b1;
			end
			4'b0111: begin
				kind = 3;
				imm = 1'b1;
			end
			4'b1110: begin
				kind = 6;
				imm = 1'b1;
			end
			default: ;
		endcase
		// immediate forms address r16..r31 only
		if (imm) begin
			d = {1'b1, w[7:4]};
			b = {w[11:8], w[3:0]};
		end
		pc = pc + 1;
		if (w[15:12] == 4'b1100) begin
			// jump to self ends the program
			if (w[11:0] == 12'hfff)
				break;
			pc = pc + int'($signed(w[11:0]));
		end else if (w[15:11] == 5'b11110) begin
			// bit 10 clear branches on a set flag, set on a clear flag
			if (f[w[2:0]] != w[10])
				pc = pc + int'($signed(w[9:3]));
		end else if (w[15:11] == 5'b10111) begin
			writes.push_back({16'({w[10:9], w[3:0]}) + 16'h0020, r[w[8:4]]});
		end else if (kind != 0) begin
			a = r[d];
			cin = carry & f[0];
			c = f[0];
			v = 1'b0;
			if (kind == 1) begin
				res = a + b + 8'(cin);
				// carry out when the true sum passes 255
				c = (int'(a) + int'(b) + int'(cin)) > 255;
				v = (a[7] == b[7]) && (res[7] != a[7]);
			end else if (kind == 2) begin
				res = a - b - 8'(cin);
				// borrow when the subtrahend plus carry exceeds Rd
				c = ({1'b0, a} < {1'b0, b} + 9'(cin));
				v = (a[7] != b[7]) && (res[7] != a[7]);
			end else if (kind == 3) begin
				res = a & b;
			end else if (kind == 4) begin
				res = a | b;
			end else if (kind == 5) begin
				res = a ^ b;
			end else begin
				res = b;
			end
			if (kind != 6) begin
				n = res[7];
				z = (res == 8'h00) && !(kind == 2 && carry && !f[1]);
				f = {3'b000, n ^ v, v, n, z, c};
			end
			if (store)
				r[d] = res;
		end
	end
endfunction

`endif

/* tb_risc8_core.sv */
/*
 * programs for the two-stage core are assembled from encoder helpers
 * each test resets the core, so register contents carry over but sreg does not
 */
module tb_risc8_core;
	import risc8_pkg::*;
	timeunit 1ns;
	timeprecision 100ps;

	logic clk;
	logic reset;
	pc_t pc;
	opcode_t cdata;
	addr_t data_addr;
	logic data_wen;
	byte_t data_write;

	opcode_t rom [256];
	opcode_t prog[$];
	logic [23:0] exp_q[$];
	int got;
	int errors;
	int tests;
	int failed;
	int cycles;
	int budget;

	`include "tb_risc8_model.svh"

	risc8_core dut (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.cdata(cdata),
		.data_addr(data_addr),
		.data_wen(data_wen),
		.data_write(data_write)
	);

	always #4 clk = ~clk;

	// program memory with one cycle of read latency
	always @(posedge clk)
		cdata <= rom[pc[7:0]];

	function automatic opcode_t reg_op(input logic [5:0] op, input reg_sel_t d, input reg_sel_t r);
		return {op, r[4], d, r[3:0]};
	endfunction

	function automatic opcode_t imm_op(input logic [3:0] op, input reg_sel_t d, input byte_t k);
		return {op, k[7:4], d[3:0], k[3:0]};
	endfunction

	function automatic opcode_t rjmp_word(input logic [11:0] k);
		return {4'b1100, k};
	endfunction

	function automatic opcode_t branch_word(input logic clr, input logic [2:0] s,
			input logic [6:0] k);
		return {5'b11110, clr, k, s};
	endfunction

	function automatic opcode_t out_word(input logic [5:0] a, input reg_sel_t r);
		return {5'b10111, a[5:4], r, a[3:0]};
	endfunction

	task automatic compare_value(input string name, input logic [15:0] val,
			input logic [15:0] exp);
		if (val !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, val, exp);
			errors++;
		end
	endtask

	// each strobe consumes one entry of exp_q
	always @(posedge clk) begin
		if (!reset && data_wen) begin
			if (got < exp_q.size()) begin
				compare_value("data_addr", data_addr, exp_q[got][23:8]);
				compare_value("data_write", 16'(data_write), 16'(exp_q[got][7:0]));
			end else begin
				$display("unexpected extra write to %h with data %h", data_addr, data_write);
				errors++;
			end
			got++;
		end
	end

	// the watchdog budget grows with each test's model length
	always @(posedge clk) begin
		cycles++;
		if (cycles > budget) begin
			$display("watchdog: run did not finish within %0d cycles", budget);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic run_program(input string name);
		int steps;
		int cyc;
		int errors_before;
		errors_before = errors;
		// every program parks on a jump to itself
		prog.push_back(rjmp_word(12'hfff));
		expected_writes(prog, exp_q, steps);
		budget += steps * 4 + 64;
		reset = 1'b1;
		for (int i = 0; i < 256; i++)
			rom[i] = (i < prog.size()) ? prog[i] : {8'h00, 8'(i)};
		repeat (5) @(negedge clk);
		// in reset the core fetches word 0 and keeps the data port quiet
		compare_value("pc", pc, 16'h0000);
		compare_value("data_wen", 16'(data_wen), 16'h0000);
		got = 0;
		reset = 1'b0;
		cyc = 0;
		while (got < exp_q.size() && cyc < steps * 4 + 32) begin
			@(negedge clk);
			cyc++;
		end
		// let the end loop spin to catch stray writes
		repeat (16) @(negedge clk);
		if (got < exp_q.size()) begin
			$display("only %0d of %0d expected writes appeared", got, exp_q.size());
			errors++;
		end
		// the core must be parked on the final jump to itself
		compare_value("pc", pc, 16'(prog.size() - 1));
		tests++;
		if (errors != errors_before)
			failed++;
		$display("test %s: %0d writes expected, %0d seen, %0d errors", name, exp_q.size(), got,
			errors - errors_before);
		prog.delete();
	endtask

	initial begin
		logic [5:0] reg_ops [10];
		logic [3:0] imm_ops [6];
		byte_t x;
		clk = 1'b0;
		reset = 1'b1;
		cdata = '0;
		got = 0;
		errors = 0;
		tests = 0;
		failed = 0;
		cycles = 0;
		budget = 200;
		void'($urandom(32'hf3be));
		reg_ops = '{6'b000011, 6'b000111, 6'b000110, 6'b000010, 6'b000101,
			6'b000001, 6'b001000, 6'b001010, 6'b001001, 6'b001011};
		imm_ops = '{4'b0011, 4'b0100, 4'b0101, 4'b0110, 4'b0111, 4'b1110};

		// values through several I/O addresses
		for (int i = 0; i < 4; i++)
			prog.push_back(imm_op(4'b1110, reg_sel_t'(16 + i), byte_t'($urandom)));
		prog.push_back(out_word(6'h00, 5'd16));
		prog.push_back(out_word(6'h05, 5'd17));
		prog.push_back(out_word(6'h1f, 5'd18));
		prog.push_back(out_word(6'h3f, 5'd19));
		run_program("ldi_out");

		// compares send out r16, which must be untouched
		for (int i = 0; i < 10; i++) begin
			prog.push_back(imm_op(4'b1110, 5'd16, byte_t'($urandom)));
			prog.push_back(imm_op(4'b1110, 5'd17, byte_t'($urandom)));
			prog.push_back(reg_op(reg_ops[i], 5'd16, 5'd17));
			prog.push_back(out_word(6'h10, 5'd16));
		end
		for (int i = 0; i < 6; i++) begin
			prog.push_back(imm_op(4'b1110, 5'd20, byte_t'($urandom)));
			prog.push_back(imm_op(imm_ops[i], 5'd20, byte_t'($urandom)));
			prog.push_back(out_word(6'h11, 5'd20));
		end
		run_program("alu_random");

		// 16-bit add and subtract with the low bytes in r16 and r18
		for (int i = 0; i < 4; i++) begin
			for (int j = 0; j < 4; j++)
				prog.push_back(imm_op(4'b1110, reg_sel_t'(16 + j), byte_t'($urandom)));
			prog.push_back(reg_op((i < 2) ? 6'b000011 : 6'b000110, 5'd16, 5'd18));
			prog.push_back(reg_op((i < 2) ? 6'b000111 : 6'b000010, 5'd17, 5'd19));
			prog.push_back(imm_op(4'b0101, 5'd18, byte_t'($urandom)));
			prog.push_back(imm_op(4'b0100, 5'd19, byte_t'($urandom)));
			prog.push_back(out_word(6'h12, 5'd16));
			prog.push_back(out_word(6'h13, 5'd17));
			prog.push_back(out_word(6'h14, 5'd18));
			prog.push_back(out_word(6'h15, 5'd19));
		end
		run_program("carry_chain");

		// brbs and brbc on C, Z and N where equal operands force Z
		for (int s = 0; s < 3; s++) begin
			for (int clr = 0; clr < 2; clr++) begin
				for (int k = 0; k < 2; k++) begin
					x = byte_t'($urandom);
					prog.push_back(imm_op(4'b1110, 5'd16, x));
					prog.push_back(imm_op(4'b0011, 5'd16, (k == 0) ? x : byte_t'($urandom)));
					prog.push_back(branch_word(1'(clr), 3'(s), 7'd3));
					prog.push_back(imm_op(4'b1110, 5'd21, 8'h0f));
					prog.push_back(out_word(6'h02, 5'd21));
					prog.push_back(rjmp_word(12'd2));
					prog.push_back(imm_op(4'b1110, 5'd21, 8'hf0));
					prog.push_back(out_word(6'h03, 5'd21));
				end
			end
		end
		run_program("branches");

		prog.push_back(imm_op(4'b1110, 5'd16, 8'h11));
		prog.push_back(out_word(6'h04, 5'd16));
		prog.push_back(rjmp_word(12'd2));
		prog.push_back(out_word(6'h05, 5'd16));
		prog.push_back(out_word(6'h06, 5'd16));
		prog.push_back(out_word(6'h07, 5'd16));
		run_program("rjmp_skip");

		// each result feeds the very next instruction
		for (int i = 0; i < 4; i++) begin
			prog.push_back(imm_op(4'b1110, 5'd16, byte_t'($urandom)));
			prog.push_back(reg_op(6'b000011, 5'd16, 5'd16));
			prog.push_back(imm_op(4'b0101, 5'd16, byte_t'($urandom)));
			prog.push_back(reg_op(6'b001011, 5'd17, 5'd16));
			prog.push_back(reg_op(6'b001001, 5'd17, 5'd16));
			prog.push_back(reg_op(6'b001010, 5'd17, 5'd16));
			prog.push_back(reg_op(6'b000011, 5'd16, 5'd17));
			prog.push_back(out_word(6'h08, 5'd16));
			prog.push_back(out_word(6'h09, 5'd17));
		end
		run_program("back_to_back");

		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* risc8_core.f */
+incdir+.
risc8_pkg.sv
risc8_alu.sv
risc8_regs.sv
risc8_decode.sv
risc8_execute.sv
risc8_core.sv
tb_risc8_core.sv

/* run_sim.sh */
#!/bin/bash
# build and run with Verilator, then look for the fail message in the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f risc8_core.f --top-module tb_risc8_core -o tb_sim \
	&& ./obj_dir/tb_sim 2>&1 | tee sim.log \
	&& ! grep -q '\*\* FAIL \*\*' sim.log \
	&& grep -q '\*\* PASS \*\*' sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
